/* Makefile */
# Verilator build for the AES-128 decryption profiler.
VERILATOR  ?= verilator
TOP        := aesProfileTb
FILELIST   := aesProfile.f
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
PASS_MSG   := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* aesProfile.f */
design/aesPkg.sv
design/aesHexDisplay.sv
design/aesKeyExpander.sv
design/aesInvRounds.sv
design/aesApbRegs.sv
design/aesProfileTop.sv
verification/aesProfile_properties.sv
verification/aesProfileTb.sv

/* design/aesApbRegs.sv */
// APB register stage of the AES profiler.
// Holds ciphertext, key and display select, launches jobs to the key expander,
// and records the plaintext and the measured start-to-done latency.
`timescale 1ns/100ps
`default_nettype none

module aesApbRegs (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire aesPkg::ApbReq   apbReq,
  output aesPkg::ApbRsp        apbRsp,
  input  wire logic            keyIdle,
  output aesPkg::KeyJob        keyJob,
  input  wire aesPkg::DoneInfo doneInfo,
  output logic [31:0]          dispWord
);

  import aesPkg::*;

  aesBlock     ctReg;
  aesBlock     keyReg;
  aesBlock     ptReg;
  logic [31:0] cyclesReg;
  logic [31:0] cycleCnt;
  logic [2:0]  dispSel;
  logic [1:0]  inFlight;  // jobs between start and doneInfo.
  logic        done;
  logic        busy;
  logic        keyValid;
  logic        wrAcc;
  logic [1:0]  wordIdx;
  logic        startReq;
  logic        startOk;
  logic        startErr;
  logic [31:0] readData;

  // word 0 is the most significant word of a block.
  function automatic logic [31:0] wordOf(input aesBlock b, input logic [1:0] idx);
    return b[32*(3 - int'(idx)) +: 32];
  endfunction

  assign wrAcc    = apbReq.psel && apbReq.penable && apbReq.pwrite;
  assign wordIdx  = apbReq.paddr[3:2];
  assign startReq = wrAcc && (apbReq.paddr == CTRL) && apbReq.pwdata[0];
  assign startOk  = startReq && keyIdle;
  assign startErr = startReq && !keyIdle;  // refused and flagged in the access phase.
  assign busy     = (inFlight != 2'd0);

  // the host cannot write between the start and the expander accept edge.
  assign keyJob = '{valid: keyValid, ct: ctReg, key: keyReg};
  assign apbRsp = '{prdata: readData, pready: 1'b1, pslverr: startErr};

  always_comb begin
    readData = 32'h0;  // unmapped offsets and CTRL read as zero.
    if (apbReq.psel && !apbReq.pwrite) begin
      if (apbReq.paddr[7:4] == CT_BASE[7:4])       readData = wordOf(ctReg, wordIdx);
      else if (apbReq.paddr[7:4] == KEY_BASE[7:4]) readData = wordOf(keyReg, wordIdx);
      else if (apbReq.paddr[7:4] == PT_BASE[7:4])  readData = wordOf(ptReg, wordIdx);
      else if (apbReq.paddr == STATUS)             readData = {30'h0, busy, done};
      else if (apbReq.paddr == CYCLES)             readData = cyclesReg;
      else if (apbReq.paddr == DISP_SEL)           readData = {29'h0, dispSel};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ctReg     <= '0;
      keyReg    <= '0;
      ptReg     <= '0;
      cyclesReg <= 32'h0;
      cycleCnt  <= 32'h0;
      dispSel   <= 3'd0;
      inFlight  <= 2'd0;
      done      <= 1'b0;
      keyValid  <= 1'b0;
    end else begin
      keyValid <= startOk;  // one-cycle pulse right after the start edge.
      if (wrAcc && apbReq.paddr[7:4] == CT_BASE[7:4]) begin
        ctReg[32*(3 - int'(wordIdx)) +: 32] <= apbReq.pwdata;
      end
      if (wrAcc && apbReq.paddr[7:4] == KEY_BASE[7:4]) begin
        keyReg[32*(3 - int'(wordIdx)) +: 32] <= apbReq.pwdata;
      end
      if (wrAcc && apbReq.paddr == DISP_SEL) dispSel <= apbReq.pwdata[2:0];
      inFlight <= inFlight + 2'(startOk) - 2'(doneInfo.valid);
      if (startOk) begin
        done     <= 1'b0;
        cycleCnt <= 32'd1;  // counts the start edge itself.
      end else if (busy) begin
        cycleCnt <= cycleCnt + 32'd1;
      end
      if (doneInfo.valid) ptReg <= doneInfo.pt;  // the last job's plaintext stays.
      // done and CYCLES belong to the most recent start, so they wait for the last job.
      if (doneInfo.valid && !startOk && inFlight == 2'd1) begin
        done      <= 1'b1;
        cyclesReg <= cycleCnt;
      end
    end
  end

  always_comb begin
    case (dispSel)
      3'd0:    dispWord = {ctReg[127:112], ctReg[15:0]};
      3'd1:    dispWord = {keyReg[127:112], keyReg[15:0]};
      3'd2:    dispWord = {ptReg[127:112], ptReg[15:0]};
      3'd3:    dispWord = cyclesReg;
      default: dispWord = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

/* design/aesHexDisplay.sv */
// Eight-digit hex display driver.
// Splits a 32-bit word into nibbles and decodes each one to active-low
// seven-segment patterns, with digit 0 showing the least significant nibble.
`timescale 1ns/100ps
`default_nettype none

module aesHexDisplay (
  input  wire logic [31:0]     dispWord,
  output logic [7:0][6:0]      hexSeg
);

  // segment bits are gfedcba and a lit segment is a 0.
  function automatic logic [6:0] segOf(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'hA:    seg = 7'b0001000;
      4'hB:    seg = 7'b0000011;  // lower-case b so it differs from 8.
      4'hC:    seg = 7'b1000110;
      4'hD:    seg = 7'b0100001;  // lower-case d so it differs from 0.
      4'hE:    seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // every digit uses the same decoder.
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      hexSeg[i] = segOf(dispWord[4*i +: 4]);
    end
  end

endmodule

`default_nettype wire

/* design/aesInvRounds.sv */
// AES-128 inverse-round stage.
// Copies a full key bank and the ciphertext, then runs the ten inverse
// rounds one per cycle and reports the plaintext with a one-cycle pulse.
`timescale 1ns/100ps
`default_nettype none

module aesInvRounds (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire aesPkg::RoundJob roundJob,
  output logic                 roundReady,
  output aesPkg::DoneInfo      doneInfo
);

  import aesPkg::*;

  logic        active;    // a block is being decrypted.
  logic [3:0]  keyIdx;    // round key used by the round in progress.
  logic        capture;
  logic        lastRound;
  aesBlock     state;
  RoundKeyBank bankHeld;  // private copy so the expander can start the next key.
  aesBlock     shifted;
  aesBlock     subbed;
  aesBlock     added;
  aesBlock     mixed;
  aesBlock     roundOut;

  // row r of the state moves right by r columns. Byte 4c+r sits at row r, column c.
  function automatic aesBlock invShiftRows(input aesBlock s);
    aesBlock r;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c - row + 4) % 4) + row) -: 8];
      end
    end
    return r;
  endfunction

  assign roundReady = !active;
  assign capture    = roundJob.valid && !active;  // the hand-off edge.
  assign lastRound  = (keyIdx == 4'd0);

  // one inverse round per cycle.
  always_comb begin
    shifted = invShiftRows(state);
    for (int i = 0; i < 16; i++) begin
      subbed[8*i +: 8] = invSubByte(shifted[8*i +: 8]);
    end
    added = subbed ^ bankHeld[keyIdx];
    for (int c = 0; c < 4; c++) begin
      mixed[32*c +: 32] = invMixColumn(added[32*c +: 32]);
    end
    roundOut = lastRound ? added : mixed;  // the final round has no column mix.
  end

  // the pulse comes with the tenth round, which ends JOB_LATENCY cycles after start.
  assign doneInfo = '{valid: active && lastRound, pt: roundOut};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      active <= 1'b0;
      keyIdx <= 4'd0;
    end else begin
      if (capture) begin
        active <= 1'b1;
        keyIdx <= 4'(NUM_ROUNDS - 1);  // round 1 uses key 9.
      end else if (active) begin
        if (lastRound) begin
          active <= 1'b0;
        end else begin
          keyIdx <= keyIdx - 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      state    <= roundJob.ct ^ roundJob.bank[NUM_ROUNDS];  // initial key addition.
      bankHeld <= roundJob.bank;
    end else if (active) begin
      state <= roundOut;
    end
  end

endmodule

`default_nettype wire

/* design/aesKeyExpander.sv */
// AES-128 key expander.
// Builds the eleven round keys one per cycle into a bank, then offers the
// bank with the ciphertext to the inverse-round stage and holds it until taken.
`timescale 1ns/100ps
`default_nettype none

module aesKeyExpander (
  input  wire logic           clk,
  input  wire logic           reset_n,
  input  wire aesPkg::KeyJob  keyJob,
  output logic                keyIdle,
  output aesPkg::RoundJob     roundJob,
  input  wire logic           roundReady
);

  import aesPkg::*;

  logic        expanding;   // round keys are still being generated.
  logic        offerValid;  // a complete bank waits for the round stage.
  logic [3:0]  keyIdx;      // index of the round key written next.
  logic [7:0]  rcon;        // round constant for keyIdx.
  RoundKeyBank bank;
  aesBlock     ctHeld;

  // one step of the schedule. The first word mixes in the rotated, substituted last word.
  function automatic aesBlock nextKey(input aesBlock prev, input logic [7:0] rc);
    logic [31:0] w0, w1, w2, w3;
    logic [31:0] rot;
    logic [31:0] t;
    {w0, w1, w2, w3} = prev;
    rot = {w3[23:0], w3[31:24]};
    t   = {subByte(rot[31:24]) ^ rc, subByte(rot[23:16]), subByte(rot[15:8]),
           subByte(rot[7:0])};
    w0  = w0 ^ t;
    w1  = w1 ^ w0;
    w2  = w2 ^ w1;
    w3  = w3 ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  assign keyIdle  = !expanding && !offerValid;  // no job held at all.
  assign roundJob = '{valid: offerValid, ct: ctHeld, bank: bank};

  // control. The register stage only pulses keyJob when keyIdle is high.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      expanding  <= 1'b0;
      offerValid <= 1'b0;
      keyIdx     <= 4'd0;
      rcon       <= 8'h01;
    end else begin
      if (keyJob.valid) begin
        expanding <= 1'b1;
        keyIdx    <= 4'd2;                      // keys 0 and 1 land on the accept edge.
        rcon      <= 8'h02;
      end else if (expanding) begin
        keyIdx <= keyIdx + 4'd1;
        rcon   <= xtime(rcon);                  // 01 02 04 ... 80 1b 36.
        if (keyIdx == 4'(NUM_ROUNDS)) begin
          expanding  <= 1'b0;                   // the last key goes in this cycle.
          offerValid <= 1'b1;
        end
      end else if (offerValid && roundReady) begin
        offerValid <= 1'b0;                     // the round stage copied the bank.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keyJob.valid) begin
      bank[0] <= keyJob.key;
      bank[1] <= nextKey(keyJob.key, 8'h01);
      ctHeld  <= keyJob.ct;
    end else if (expanding) begin
      bank[keyIdx] <= nextKey(bank[4'(keyIdx - 4'd1)], rcon);
    end
  end

endmodule

`default_nettype wire

/* design/aesPkg.sv */
// AES-128 profiling subsystem shared definitions.
// Holds the APB register map, the stage hand-off structs and the GF(2^8)
// arithmetic behind the S-box, the inverse S-box and the inverse column mix.
`default_nettype none

package aesPkg;

  localparam int NUM_ROUNDS  = 10;  // AES-128 runs ten rounds.
  localparam int JOB_LATENCY = 21;  // start write to done flag when the pipeline is idle.

  // register offsets on the APB bus. Data words are stored with word 0 as the most significant.
  localparam logic [7:0] CT_BASE  = 8'h00;
  localparam logic [7:0] KEY_BASE = 8'h10;
  localparam logic [7:0] PT_BASE  = 8'h20;
  localparam logic [7:0] CTRL     = 8'h30;
  localparam logic [7:0] STATUS   = 8'h34;
  localparam logic [7:0] CYCLES   = 8'h38;
  localparam logic [7:0] DISP_SEL = 8'h3C;

  typedef logic [127:0] aesBlock;                    // one state, key or round key.
  typedef aesBlock [NUM_ROUNDS:0] RoundKeyBank;      // entry 0 is the cipher key.

  typedef struct packed {
    logic    valid;
    aesBlock ct;
    aesBlock key;
  } KeyJob;

  typedef struct packed {
    logic        valid;
    aesBlock     ct;
    RoundKeyBank bank;
  } RoundJob;

  typedef struct packed {
    logic    valid;
    aesBlock pt;
  } DoneInfo;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } ApbReq;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } ApbRsp;

  // multiply by x in GF(2^8) with the AES reduction polynomial.
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // shift and add multiplier. Each set bit of b adds the current multiple of a.
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] part;
    acc  = 8'h00;
    part = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc = acc ^ part;
      part = xtime(part);
    end
    return acc;
  endfunction

  // the inverse is a^254, built from the squares a^2 up to a^128. Zero maps to zero.
  function automatic logic [7:0] gfInv(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] acc;
    sq  = a;
    acc = 8'h01;
    for (int i = 1; i < 8; i++) begin
      sq  = gfMul(sq, sq);
      acc = gfMul(acc, sq);
    end
    return acc;
  endfunction

  function automatic logic [7:0] subByte(input logic [7:0] a);
    logic [7:0] b;
    b = gfInv(a);
    // affine map is b xor its four left rotations, plus the constant 63.
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [7:0] invSubByte(input logic [7:0] s);
    logic [7:0] b;
    b = {s[6:0], s[7]} ^ {s[4:0], s[7:5]} ^ {s[1:0], s[7:2]} ^ 8'h05;  // undo the affine map.
    return gfInv(b);
  endfunction

  // inverse column mix on one column. The top byte is row 0.
  function automatic logic [31:0] invMixColumn(input logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    {a0, a1, a2, a3} = col;
    return {gfMul(a0, 8'h0e) ^ gfMul(a1, 8'h0b) ^ gfMul(a2, 8'h0d) ^ gfMul(a3, 8'h09),
            gfMul(a0, 8'h09) ^ gfMul(a1, 8'h0e) ^ gfMul(a2, 8'h0b) ^ gfMul(a3, 8'h0d),
            gfMul(a0, 8'h0d) ^ gfMul(a1, 8'h09) ^ gfMul(a2, 8'h0e) ^ gfMul(a3, 8'h0b),
            gfMul(a0, 8'h0b) ^ gfMul(a1, 8'h0d) ^ gfMul(a2, 8'h09) ^ gfMul(a3, 8'h0e)};
  endfunction

endpackage

`default_nettype wire

/* design/aesProfileTop.sv */
// Top level of the AES-128 decryption profiler.
// The APB register stage feeds the key expander, which feeds the inverse-round
// stage. Results return to the register stage, which also drives the display.
`timescale 1ns/100ps
`default_nettype none

module aesProfileTop (
  input  wire logic          clk,
  input  wire logic          reset_n,
  input  wire aesPkg::ApbReq apbReq,
  output aesPkg::ApbRsp      apbRsp,
  output logic [7:0][6:0]    hexSeg
);

  import aesPkg::*;

  KeyJob       keyJob;      // register stage to expander.
  logic        keyIdle;
  RoundJob     roundJob;    // expander to round stage.
  logic        roundReady;
  DoneInfo     doneInfo;    // round stage back to the registers.
  logic [31:0] dispWord;

  aesApbRegs u_aesApbRegs (
    .clk      (clk),
    .reset_n  (reset_n),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .keyIdle  (keyIdle),
    .keyJob   (keyJob),
    .doneInfo (doneInfo),
    .dispWord (dispWord)
  );

  aesKeyExpander u_aesKeyExpander (
    .clk        (clk),
    .reset_n    (reset_n),
    .keyJob     (keyJob),
    .keyIdle    (keyIdle),
    .roundJob   (roundJob),
    .roundReady (roundReady)
  );

  aesInvRounds u_aesInvRounds (
    .clk        (clk),
    .reset_n    (reset_n),
    .roundJob   (roundJob),
    .roundReady (roundReady),
    .doneInfo   (doneInfo)
  );

  aesHexDisplay u_aesHexDisplay (
    .dispWord (dispWord),
    .hexSeg   (hexSeg)
  );

endmodule

`default_nettype wire

/* verification/aesProfileTb.sv */
// Testbench for the AES-128 decryption profiler.
// Loads known FIPS-197 vectors over APB, then checks plaintext, latency,
// the refused start, the display decoding and the state after reset.
`timescale 1ns/100ps
`default_nettype none

module aesProfileTb;

  import aesPkg::*;

  localparam int      CLK_HALF   = 2;     // 4 ns period.
  localparam int      TIMEOUT    = 2000;  // about four times the summed test length.
  localparam int      POLL_LIMIT = 40;    // STATUS polls before a job counts as hung.
  localparam aesBlock FIPS_KEY   = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aesBlock FIPS_CT    = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aesBlock FIPS_PT    = 128'h00112233445566778899aabbccddeeff;
  localparam aesBlock ALT_KEY    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aesBlock ALT_CT     = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam aesBlock ALT_PT     = 128'h3243f6a8885a308d313198a2e0370734;

  logic            clk = 1'b0;
  logic            reset_n;
  ApbReq           apbReq;
  ApbRsp           apbRsp;
  logic [7:0][6:0] hexSeg;

  int    cycleCount  = 0;
  int    checkCount  = 0;
  int    errCount    = 0;
  int    testsPassed = 0;
  int    testsFailed = 0;
  int    testErrBase = 0;
  int    propBase    = 0;
  string curTest;
  // lit segments per hex digit, bit 6 is g and bit 0 is a. The display drives them inverted.
  logic [6:0] litSeg [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                              7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

  aesProfileTop u_aesProfileTop (
    .clk     (clk),
    .reset_n (reset_n),
    .apbReq  (apbReq),
    .apbRsp  (apbRsp),
    .hexSeg  (hexSeg)
  );

  always #(CLK_HALF) clk = !clk;

  // the run is cut off if a handshake never completes.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // one APB transfer. Response is sampled at the falling edge of the access phase.
  task automatic apbXfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic err);
    int waitCycles;
    waitCycles = 0;
    @(posedge clk);
    #1;
    apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apbReq.penable = 1'b1;
    @(negedge clk);
    while (!apbRsp.pready && waitCycles < POLL_LIMIT) begin
      waitCycles++;
      @(negedge clk);
    end
    if (!apbRsp.pready) begin
      errCount++;
      $display("%s: transfer to offset %h never completed, pready stayed low", curTest, addr);
    end
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
    @(posedge clk);  // the edge that ends the access phase.
    #1;
    apbReq = '0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apbXfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apbXfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic checkWord(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("ERR %s %s expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic readCheck(input logic [7:0] addr, input logic [31:0] expected,
                           input string what);
    logic [31:0] data;
    apbRead(addr, data);
    checkWord(what, expected, data);
  endtask

  // block registers hold word 0 as the most significant word.
  task automatic writeBlock(input logic [7:0] base, input aesBlock value);
    logic err;
    for (int i = 0; i < 4; i++) begin
      apbWrite(base + 8'(4 * i), value[127 - 32 * i -: 32], err);
    end
  endtask

  task automatic readCheckBlock(input logic [7:0] base, input aesBlock expected,
                                input string what);
    logic [31:0] data;
    for (int i = 0; i < 4; i++) begin
      apbRead(base + 8'(4 * i), data);
      checkWord($sformatf("%s word %0d", what, i), expected[127 - 32 * i -: 32], data);
    end
  endtask

  task automatic startJob(input logic expectErr);
    logic err;
    apbWrite(CTRL, 32'h1, err);
    checkWord("pslverr on start", {31'h0, expectErr}, {31'h0, err});
  endtask

  // polls STATUS until done is set and busy is clear.
  task automatic waitDone();
    logic [31:0] status;
    int          polls;
    status = 32'h0;
    polls  = 0;
    while (status[1:0] != 2'b01 && polls < POLL_LIMIT) begin
      apbRead(STATUS, status);
      polls++;
    end
    if (status[1:0] != 2'b01) begin
      errCount++;
      $display("%s: job did not finish, STATUS stayed at %h", curTest, status);
    end
  endtask

  task automatic idleGap();
    repeat ($urandom_range(3, 0)) @(posedge clk);
  endtask

  task automatic runVector(input aesBlock key, input aesBlock ct, input aesBlock pt);
    writeBlock(CT_BASE, ct);
    idleGap();
    writeBlock(KEY_BASE, key);
    idleGap();
    readCheckBlock(CT_BASE, ct, "ciphertext readback");
    startJob(1'b0);
    waitDone();
    readCheckBlock(PT_BASE, pt, "plaintext");
    readCheck(CYCLES, 32'(JOB_LATENCY), "CYCLES");
  endtask

  // active-low pattern of all eight digits, digit 0 from the lowest nibble.
  function automatic logic [55:0] segsFor(input logic [31:0] word);
    logic [55:0] segs;
    for (int d = 0; d < 8; d++) begin
      segs[7 * d +: 7] = ~litSeg[word[4 * d +: 4]];
    end
    return segs;
  endfunction

  task automatic checkDisplay(input logic [2:0] sel, input logic [31:0] word);
    logic err;
    apbWrite(DISP_SEL, {29'h0, sel}, err);
    @(negedge clk);  // the display is combinational from the select register.
    checkCount++;
    if (hexSeg !== segsFor(word)) begin
      errCount++;
      $display("ERR %s select %0d expected %h actual %h", curTest, sel, segsFor(word), hexSeg);
    end
  endtask

  task automatic beginTest(input string name);
    curTest     = name;
    testErrBase = errCount;
    propBase    = u_aesProfileTop.u_aesApbRegs.u_aesProfileProps.failCount;
  endtask

  task automatic endTest();
    int errs;
    int props;
    errs  = errCount - testErrBase;
    props = u_aesProfileTop.u_aesApbRegs.u_aesProfileProps.failCount - propBase;
    if (errs == 0 && props == 0) begin
      testsPassed++;
      $display("test %s: ok", curTest);
    end else begin
      testsFailed++;
      $display("test %s: failed, %0d value errors, %0d assertion failures", curTest, errs, props);
    end
  endtask

  initial begin
    int propFails;
    void'($urandom(32'h6778));
    curTest  = "reset";
    reset_n  = 1'b0;
    apbReq   = '0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    beginTest("resetDefaults");
    readCheck(STATUS, 32'h0, "STATUS");
    readCheck(8'h44, 32'h0, "unmapped offset 44");
    readCheck(8'hF0, 32'h0, "unmapped offset F0");
    endTest();

    beginTest("fipsVector");
    runVector(FIPS_KEY, FIPS_CT, FIPS_PT);
    endTest();

    beginTest("secondVector");
    runVector(ALT_KEY, ALT_CT, ALT_PT);
    endTest();

    beginTest("latency");  // the bound assertion times the done edge.
    idleGap();
    startJob(1'b0);
    waitDone();
    readCheck(CYCLES, 32'(JOB_LATENCY), "CYCLES");
    readCheck(STATUS, 32'h1, "STATUS");
    endTest();

    beginTest("refusedStart");
    writeBlock(CT_BASE, FIPS_CT);
    writeBlock(KEY_BASE, FIPS_KEY);
    startJob(1'b0);
    startJob(1'b1);  // the expander is still building round keys.
    waitDone();
    readCheckBlock(PT_BASE, FIPS_PT, "plaintext");
    readCheck(CYCLES, 32'(JOB_LATENCY), "CYCLES");
    endTest();

    beginTest("display");
    checkDisplay(3'd0, {FIPS_CT[127:112], FIPS_CT[15:0]});
    checkDisplay(3'd1, {FIPS_KEY[127:112], FIPS_KEY[15:0]});
    checkDisplay(3'd2, {FIPS_PT[127:112], FIPS_PT[15:0]});
    checkDisplay(3'd3, 32'(JOB_LATENCY));
    checkDisplay(3'd5, 32'h0);
    endTest();

    propFails = u_aesProfileTop.u_aesApbRegs.u_aesProfileProps.failCount;
    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors, %0d assertion fails",
             testsPassed, testsFailed, checkCount, errCount, propFails);
    if (errCount == 0 && propFails == 0 && testsFailed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/aesProfile_properties.sv */
// Concurrent checks on the APB register stage of the AES profiler.
// Bound into aesApbRegs. Covers the APB ready response, the STATUS word
// while a job runs, and the start-to-done latency on an idle pipeline.
`timescale 1ns/100ps
`default_nettype none

module aesProfile_properties (
  input wire logic          clk,
  input wire logic          reset_n,
  input wire aesPkg::ApbReq apbReq,
  input wire aesPkg::ApbRsp apbRsp,
  input wire logic          keyIdle,
  input wire logic          busy,
  input wire logic          done
);

  import aesPkg::*;

  int   readyFails = 0;    // one counter per assertion.
  int   statusFails = 0;
  int   latencyFails = 0;
  int   failCount;         // total of all failed assertions so far.
  logic accessPhase;
  logic statusRead;
  logic idleStart;

  assign failCount   = readyFails + statusFails + latencyFails;
  assign accessPhase = apbReq.psel && apbReq.penable;
  assign statusRead  = apbReq.psel && !apbReq.pwrite && (apbReq.paddr == STATUS);
  // a start that the expander accepts while no other job is in flight.
  assign idleStart   = accessPhase && apbReq.pwrite && (apbReq.paddr == CTRL) &&
                       apbReq.pwdata[0] && keyIdle && !busy;

  // the slave never inserts wait states.
  readyInAccess: assert property (@(posedge clk) disable iff (!reset_n)
    accessPhase |-> apbRsp.pready)
    else begin
      readyFails++;
      $error("pready was low in an APB access phase");
    end

  // done belongs to the previous job and is cleared at the start edge.
  doneLowWhileBusy: assert property (@(posedge clk) disable iff (!reset_n)
    statusRead && busy |-> !apbRsp.prdata[0])
    else begin
      statusFails++;
      $error("STATUS showed done while busy was set");
    end

  // done is written on the edge JOB_LATENCY cycles after the start edge,
  // so its new value is sampled one edge later.
  latencyToDone: assert property (@(posedge clk) disable iff (!reset_n)
    idleStart |-> ##(JOB_LATENCY + 1) $rose(done))
    else begin
      latencyFails++;
      $error("done did not rise %0d cycles after an idle start", JOB_LATENCY);
    end

endmodule

bind aesApbRegs aesProfile_properties u_aesProfileProps (
  .clk     (clk),
  .reset_n (reset_n),
  .apbReq  (apbReq),
  .apbRsp  (apbRsp),
  .keyIdle (keyIdle),
  .busy    (busy),
  .done    (done)
);

`default_nettype wire
